// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_aes_tx
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "FAIL: pass message missing in $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/aes_defines.svh
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// Number of independent AES3 lanes driven from the shared subframe feeder
`define AES_LANES 4

// Audio word width carried in slots 4 to 27 of every subframe
`define AES_SAMPLE_W 24

// Slots in one subframe, which is also the word select half period in clocks
`define AES_SLOTS 32

// Frames in one channel status block, one C bit taken per frame
`define AES_BLOCK_FRAMES 192

`endif

// File: sim.f
+incdir+include
verilog/aes_frame_pkg.sv
verilog/aes_line_pkg.sv
verilog/aes_subframe_feeder.sv
verilog/aes_lane_encoder.sv
verilog/aes_line_output.sv
verilog/aes_tx_top.sv
verification/tb_aes_tx.sv

// File: verification/tb_aes_tx.sv
`timescale 1ns/1ps
`include "aes_defines.svh"

module tb_aes_tx;
  import aes_frame_pkg::*;
  import aes_line_pkg::*;

  localparam int LANES        = `AES_LANES;
  localparam int SW           = `AES_SAMPLE_W;
  localparam int BLOCK        = `AES_BLOCK_FRAMES;
  localparam int RUN_REQS     = 450;
  localparam int REQ_TIMEOUT  = 64;
  localparam int HUNT_TIMEOUT = 200;
  localparam int WARMUP       = 40;
  // Frames a lane must decode even with its enable gap and the relock after it
  localparam int MIN_FRAMES   = RUN_REQS - 40;

  // AES3 preambles after a line that ended low with the first half-cell in the MSB
  localparam logic [7:0] PAT_X = 8'b1110_0010;
  localparam logic [7:0] PAT_Y = 8'b1110_0100;
  localparam logic [7:0] PAT_Z = 8'b1110_1000;
  // Preamble kinds used by the model
  localparam int K_NONE = 0;
  localparam int K_X    = 1;
  localparam int K_Y    = 2;
  localparam int K_Z    = 3;

  // A captured pair and the number of the sample_req that took it
  typedef struct packed {
    int        idx;
    pcm_pair_t pair;
  } sent_pair_t;

  logic                  aud_clk;
  logic                  rst;
  pcm_pair_t [LANES-1:0] pcm_in;
  cs_fields_t            cs_fields;
  logic [LANES-1:0]      lane_en;
  logic                  sample_req;
  line_sym_t [LANES-1:0] line_out;

  // Expected pairs per lane and the channel status of every block
  sent_pair_t sent_q [LANES][$];
  cs_fields_t block_cs_q [$];

  // --------------------------------------------------
  // Decoder state with one entry per lane
  // --------------------------------------------------
  logic [7:0]  hist      [LANES];
  logic [31:0] sf_bits   [LANES];
  logic [31:0] left_bits [LANES];
  logic [4:0]  slot      [LANES];
  logic        locked    [LANES];
  logic        in_pre    [LANES];
  logic        level     [LANES];
  logic        resync    [LANES];
  int          pre_kind  [LANES];
  int          last_kind [LANES];
  int          misses    [LANES];
  int          hunt_cnt  [LANES];
  int          en_cycles [LANES];
  int          frames_checked [LANES];

  int               errors;
  int               checks;
  int               req_count;
  int               since_req;
  int               cycles;
  int               total_frames;
  logic             timed_out;
  logic             refresh_pcm;
  logic             refresh_cs;
  logic [LANES-1:0] en_used;

  aes_tx_top u_dut (
    .aud_clk    (aud_clk),
    .rst        (rst),
    .pcm_in     (pcm_in),
    .cs_fields  (cs_fields),
    .lane_en    (lane_en),
    .sample_req (sample_req),
    .line_out   (line_out)
  );

  initial begin
    aud_clk = 1'b0;
    forever #20 aud_clk = ~aud_clk;
  end

  // Last line of defence in case the main loop stalls
  initial begin
    #((RUN_REQS + 10) * 64 * 40);
    $display("Simulation time limit reached before the run finished");
    $display("Test failed");
    $finish;
  end

  task automatic report_value(int lane, string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("Error: lane %0d %s = %h, expected %h", lane, name, got, exp);
  endtask

  // Kind of preamble in 8 half-cells in either polarity
  function automatic int preamble_kind(logic [7:0] h);
    logic [7:0] p;
    p = h[7] ? h : ~h;
    if (p === PAT_X) return K_X;
    if (p === PAT_Y) return K_Y;
    if (p === PAT_Z) return K_Z;
    return K_NONE;
  endfunction

  // Channel status bit n of the block where byte 0 and byte 1 carry the fields
  function automatic logic expected_c(cs_fields_t cs, int n);
    logic b;
    case (n)
      0:             b = cs.professional;
      1:             b = cs.non_audio;
      2:             b = cs.emphasis[0];
      3:             b = cs.emphasis[1];
      6:             b = cs.rate[0];
      7:             b = cs.rate[1];
      8, 9, 10, 11:  b = cs.chan_mode[n-8];
      default:       b = 1'b0;
    endcase
    return b;
  endfunction

  // Lanes are dropped one at a time and the last one across a block start
  function automatic logic [LANES-1:0] enable_pattern(int req);
    logic [LANES-1:0] en;
    en = '1;
    if (req >= 100 && req < 104) en[1] = 1'b0;
    if (req >= 250 && req < 262) en[2] = 1'b0;
    if (req >= 380 && req < 386) en[3] = 1'b0;
    return en;
  endfunction

  task automatic randomize_pcm();
    for (int l = 0; l < LANES; l++) begin
      pcm_in[l].left  = SW'($urandom());
      pcm_in[l].right = SW'($urandom());
      pcm_in[l].valid = ($urandom() % 8) != 0;
    end
  endtask

  // --------------------------------------------------
  // Compare one decoded frame with the queued pair
  // --------------------------------------------------
  task automatic check_frame(int lane, logic [31:0] lb, logic [31:0] rb, int lkind);
    sent_pair_t e;
    int         pos;
    int         n;
    logic       c_exp;
    pos = -1;
    // After a gap the lane must find its place again in the sample stream
    if (resync[lane]) begin
      for (int i = 0; i < sent_q[lane].size(); i++) begin
        if (pos < 0 && sent_q[lane][i].pair.left === lb[27:4]
            && sent_q[lane][i].pair.right === rb[27:4]) begin
          pos = i;
        end
      end
      if (pos < 0) begin
        misses[lane]++;
        assert (misses[lane] <= 4) else begin
          errors++;
          $display("Lane %0d did not pick up the sample stream again", lane);
          misses[lane] = 0;
        end
        return;
      end
      repeat (pos) void'(sent_q[lane].pop_front());
      resync[lane] = 1'b0;
      misses[lane] = 0;
    end
    assert (sent_q[lane].size() > 0) else begin
      errors++;
      $display("Lane %0d decoded a frame while no sample was queued", lane);
      return;
    end
    e     = sent_q[lane].pop_front();
    n     = e.idx % BLOCK;
    c_exp = expected_c(block_cs_q[e.idx / BLOCK], n);
    checks++;
    frames_checked[lane]++;
    assert (lb[27:4] === e.pair.left) else report_value(lane, "left", lb[27:4], e.pair.left);
    assert (rb[27:4] === e.pair.right) else report_value(lane, "right", rb[27:4], e.pair.right);
    // V goes out as the inverse of the valid flag in both subframes
    assert ({lb[28], rb[28]} === {2{~e.pair.valid}})
      else report_value(lane, "V bits", {lb[28], rb[28]}, {2{~e.pair.valid}});
    assert ({lb[29], rb[29]} === 2'b00) else report_value(lane, "U bits", {lb[29], rb[29]}, 0);
    assert ({lb[30], rb[30]} === {2{c_exp}})
      else report_value(lane, "C bits", {lb[30], rb[30]}, {2{c_exp}});
    // Z only on frame 0 of a block
    assert (lkind == ((n == 0) ? K_Z : K_X))
      else report_value(lane, "left preamble kind", lkind, (n == 0) ? K_Z : K_X);
  endtask

  // --------------------------------------------------
  // Biphase mark decoder for one clock of one lane
  // --------------------------------------------------
  task automatic decode_cycle(int lane, line_sym_t s, logic en);
    int kind;
    if (!en) begin
      // A disabled lane idles low and loses its place
      assert (s === 2'b00) else report_value(lane, "line_out", s, 0);
      locked[lane]    = 1'b0;
      last_kind[lane] = K_NONE;
      resync[lane]    = 1'b1;
      en_cycles[lane] = 0;
      hunt_cnt[lane]  = 0;
      return;
    end
    hist[lane] = {hist[lane][5:0], s.sym_first, s.sym_second};
    en_cycles[lane]++;
    kind = preamble_kind(hist[lane]);
    if (!locked[lane]) begin
      if (en_cycles[lane] >= 4 && kind != K_NONE) begin
        locked[lane]    = 1'b1;
        in_pre[lane]    = 1'b0;
        slot[lane]      = 5'd3;
        pre_kind[lane]  = kind;
        last_kind[lane] = K_NONE;
        hunt_cnt[lane]  = 0;
      end else begin
        hunt_cnt[lane]++;
        assert (hunt_cnt[lane] <= HUNT_TIMEOUT) else begin
          errors++;
          $display("Lane %0d shows no preamble for %0d cycles", lane, HUNT_TIMEOUT);
          hunt_cnt[lane] = 0;
        end
      end
      level[lane] = s.sym_second;
      return;
    end
    slot[lane] = slot[lane] + 5'd1;
    if (in_pre[lane]) begin
      // The parity slot left the line low, so the preamble starts high
      if (slot[lane] == 5'd3) begin
        in_pre[lane]   = 1'b0;
        pre_kind[lane] = kind;
        assert (kind != K_NONE && hist[lane][7] === 1'b1) else begin
          errors++;
          $display("Error: lane %0d line_out preamble = %h, expected X, Y or Z starting high",
                   lane, hist[lane]);
          locked[lane]    = 1'b0;
          last_kind[lane] = K_NONE;
          resync[lane]    = 1'b1;
        end
      end
      level[lane] = s.sym_second;
      return;
    end
    // Every cell starts with a transition
    assert (s.sym_first === ~level[lane])
      else report_value(lane, "line_out", s, {~level[lane], s.sym_second});
    sf_bits[lane][slot[lane]] = s.sym_first ^ s.sym_second;
    level[lane] = s.sym_second;
    if (slot[lane] == 5'd31) begin
      assert (^sf_bits[lane][31:4] === 1'b0)
        else report_value(lane, "subframe parity", ^sf_bits[lane][31:4], 0);
      // Left and right subframes alternate once the lane is locked
      if (last_kind[lane] != K_NONE) begin
        assert ((last_kind[lane] == K_Y) != (pre_kind[lane] == K_Y))
          else report_value(lane, "preamble kind", pre_kind[lane], last_kind[lane]);
      end
      if (pre_kind[lane] == K_Y) begin
        if (last_kind[lane] == K_X || last_kind[lane] == K_Z) begin
          check_frame(lane, left_bits[lane], sf_bits[lane], last_kind[lane]);
        end
      end else begin
        left_bits[lane] = sf_bits[lane];
      end
      last_kind[lane] = pre_kind[lane];
      in_pre[lane]    = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Stimulus and monitoring
  // --------------------------------------------------
  initial begin
    void'($urandom(32'h046b_a885));
    errors      = 0;
    checks      = 0;
    req_count   = 0;
    since_req   = 0;
    cycles      = 0;
    timed_out   = 1'b0;
    refresh_pcm = 1'b0;
    refresh_cs  = 1'b0;
    rst         = 1'b1;
    lane_en     = '1;
    en_used     = '1;
    cs_fields   = 10'($urandom());
    randomize_pcm();
    for (int l = 0; l < LANES; l++) begin
      hist[l]           = 'x;
      locked[l]         = 1'b0;
      in_pre[l]         = 1'b0;
      level[l]          = 1'b0;
      resync[l]         = 1'b1;
      last_kind[l]      = K_NONE;
      misses[l]         = 0;
      hunt_cnt[l]       = 0;
      en_cycles[l]      = 0;
      frames_checked[l] = 0;
    end
    repeat (16) @(posedge aud_clk);
    #2;
    rst = 1'b0;
    while (req_count < RUN_REQS && !timed_out) begin
      @(posedge aud_clk);
      // The enable sampled on this edge is the one line_out shows next
      en_used = lane_en;
      #2;
      if (refresh_pcm) randomize_pcm();
      if (refresh_cs) cs_fields = 10'($urandom());
      refresh_pcm = 1'b0;
      refresh_cs  = 1'b0;
      lane_en     = enable_pattern(req_count);
      @(negedge aud_clk);
      cycles++;
      if (sample_req === 1'b1) begin
        // pcm_in has been stable since the last capture and is taken on the next edge
        for (int l = 0; l < LANES; l++) begin
          sent_q[l].push_back({req_count, pcm_in[l]});
        end
        if (req_count % BLOCK == 0) begin
          block_cs_q.push_back(cs_fields);
          refresh_cs = 1'b1;
        end
        refresh_pcm = 1'b1;
        req_count++;
        since_req = 0;
      end else begin
        since_req++;
        if (since_req > REQ_TIMEOUT) begin
          errors++;
          timed_out = 1'b1;
          $display("sample_req did not arrive within %0d cycles", REQ_TIMEOUT);
        end
      end
      if (cycles > WARMUP) begin
        for (int l = 0; l < LANES; l++) begin
          decode_cycle(l, line_out[l], en_used[l]);
        end
      end
    end
    total_frames = 0;
    for (int l = 0; l < LANES; l++) begin
      total_frames += frames_checked[l];
      // Lanes with a gap still have to decode most of the run
      assert (timed_out || frames_checked[l] > MIN_FRAMES) else begin
        errors++;
        $display("Lane %0d decoded only %0d frames", l, frames_checked[l]);
      end
    end
    $display("Requests: %0d, frames checked: %0d, checks: %0d, errors: %0d",
             req_count, total_frames, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog/aes_frame_pkg.sv
`include "aes_defines.svh"

package aes_frame_pkg;

  // One PCM sample pair as presented by the audio source
  // The flag is high for a usable sample and goes out inverted as the V bit
  typedef struct packed {
    logic                     valid;
    logic [`AES_SAMPLE_W-1:0] left;
    logic [`AES_SAMPLE_W-1:0] right;
  } pcm_pair_t;

  // Channel status content carried in bytes 0 and 1 of the block
  // Everything else in the 192 bit block goes out as 0
  typedef struct packed {
    logic       professional;
    logic       non_audio;
    logic [1:0] emphasis;
    logic [1:0] rate;
    logic [3:0] chan_mode;
  } cs_fields_t;

  // Position of a frame inside the channel status block
  typedef logic [$clog2(`AES_BLOCK_FRAMES)-1:0] frame_idx_t;

  // --------------------------------------------------
  // Channel status bit for one frame of the block
  // --------------------------------------------------
  // Byte 0 holds the pro flag in bit 0, non audio in bit 1,
  // emphasis in bits 2-3 and the rate code in bits 6-7.
  // Byte 1 holds the channel mode in bits 0-3
  function automatic logic cs_block_bit(cs_fields_t cs, frame_idx_t frame);
    logic [15:0] bytes01;
    bytes01        = '0;
    bytes01[0]     = cs.professional;
    bytes01[1]     = cs.non_audio;
    bytes01[3:2]   = cs.emphasis;
    bytes01[7:6]   = cs.rate;
    bytes01[11:8]  = cs.chan_mode;
    if (frame < frame_idx_t'(16)) begin
      return bytes01[frame[3:0]];
    end
    return 1'b0;
  endfunction

endpackage

// File: verilog/aes_lane_encoder.sv
`timescale 1ns/1ps

module aes_lane_encoder (
  input  logic                    aud_clk,
  input  logic                    aud_ws,
  input  logic                    aud_data,
  output aes_line_pkg::line_sym_t sym
);
  import aes_line_pkg::*;

  // Delayed serial inputs, the delayed bit belongs to slot_cnt
  logic       ws_d1;
  logic       data_d1;
  logic [4:0] slot_cnt;

  // Preamble in use and whether it goes out inverted
  preamble_e  pre_q;
  preamble_e  pre_cur;
  logic       inv_q;
  logic       inv_cur;
  logic [7:0] pat;
  logic [2:0] idx_first;
  logic [2:0] idx_second;

  // Line level after the last half-cell sent
  logic       level;
  line_sym_t  sym_next;

  assign level = sym.sym_second;

  // --------------------------------------------------
  // Slot tracking
  // --------------------------------------------------
  // A word select edge restarts the count, so the count trails the
  // feeder by one clock and matches the slot held in data_d1
  always_ff @(posedge aud_clk) begin
    ws_d1   <= aud_ws;
    data_d1 <= aud_data;
    if (aud_ws != ws_d1) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= slot_cnt + 5'd1;
    end
  end

  // In slot 0 both code bits are visible, slot 0 delayed and slot 1 live
  assign pre_cur = (slot_cnt == 5'd0) ? preamble_sel(data_d1, aud_data) : pre_q;
  // A line that ended high flips the whole preamble
  assign inv_cur = (slot_cnt == 5'd0) ? level : inv_q;

  // Keep the choice for slots 1 to 3
  always_ff @(posedge aud_clk) begin
    if (slot_cnt == 5'd0) begin
      pre_q <= pre_cur;
      inv_q <= inv_cur;
    end
  end

  // --------------------------------------------------
  // Biphase mark coding
  // --------------------------------------------------
  always_comb begin
    pat        = pre_cur;
    // Slot k of the preamble uses pattern bits 7-2k and 6-2k
    idx_first  = {~slot_cnt[1:0], 1'b1};
    idx_second = {~slot_cnt[1:0], 1'b0};
    if (slot_cnt[4:2] == 3'd0) begin
      sym_next.sym_first  = pat[idx_first] ^ inv_cur;
      sym_next.sym_second = pat[idx_second] ^ inv_cur;
    end else if (slot_cnt == 5'd31) begin
      // Parity slot, the bit value is whatever brings the line back low.
      // With a low start this gives even parity over slots 4 to 31
      sym_next.sym_first  = ~level;
      sym_next.sym_second = 1'b0;
    end else begin
      // Always toggle at the cell start, toggle again mid cell for a 1
      sym_next.sym_first  = ~level;
      sym_next.sym_second = ~level ^ data_d1;
    end
  end

  // Output is two clocks behind the slot on aud_data
  always_ff @(posedge aud_clk) begin
    sym <= sym_next;
  end

endmodule

// File: verilog/aes_line_output.sv
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_line_output (
  input  logic                                       aud_clk,
  input  logic                                       rst,
  input  aes_line_pkg::line_sym_t [`AES_LANES-1:0]   lane_sym,
  input  logic [`AES_LANES-1:0]                      lane_en,
  output aes_line_pkg::line_sym_t [`AES_LANES-1:0]   line_out
);

  // --------------------------------------------------
  // Output register for all lanes
  // --------------------------------------------------
  // Each lane carries a half-cell pair per clock, and the pair is
  // serialized by whatever pin logic follows this block.
  // A disabled lane sends 00, which a receiver sees as an idle line.
  // Enabling it again picks up the encoder at the next clock, so the
  // far end regains lock at the next preamble
  always_ff @(posedge aud_clk) begin
    if (rst) begin
      line_out <= '0;
    end else begin
      for (int i = 0; i < `AES_LANES; i++) begin
        if (lane_en[i]) begin
          line_out[i] <= lane_sym[i];
        end else begin
          line_out[i] <= '0;
        end
      end
    end
  end

endmodule

// File: verilog/aes_line_pkg.sv
package aes_line_pkg;

  // Two half-cell symbols per lane per clock
  // sym_first goes on the line before sym_second
  typedef struct packed {
    logic sym_first;
    logic sym_second;
  } line_sym_t;

  // Preamble patterns over slots 0 to 3, MSB is the first half-cell.
  // These are the forms sent after a line that ended low
  typedef enum logic [7:0] {
    PRE_X = 8'b1110_0010,
    PRE_Y = 8'b1110_0100,
    PRE_Z = 8'b1110_1000
  } preamble_e;

  // --------------------------------------------------
  // Preamble choice from the codes in slots 0 and 1
  // --------------------------------------------------
  function automatic preamble_e preamble_sel(logic code0, logic code1);
    preamble_e pre;
    if (code0) begin
      pre = PRE_Y;
    end else if (code1) begin
      pre = PRE_Z;
    end else begin
      pre = PRE_X;
    end
    return pre;
  endfunction

endpackage

// File: verilog/aes_subframe_feeder.sv
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_subframe_feeder (
  input  logic                                      aud_clk,
  input  logic                                      rst,
  input  aes_frame_pkg::pcm_pair_t [`AES_LANES-1:0] pcm_in,
  input  aes_frame_pkg::cs_fields_t                 cs_fields,
  output logic                                      sample_req,
  output logic                                      aud_ws,
  output logic [`AES_LANES-1:0]                     aud_data
);
  import aes_frame_pkg::*;

  localparam int SLOT_W = $clog2(`AES_SLOTS);
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`AES_SLOTS - 1);
  localparam frame_idx_t LAST_FRAME = frame_idx_t'(`AES_BLOCK_FRAMES - 1);

  // Slot map of one subframe
  localparam logic [SLOT_W-1:0] CODE0_SLOT  = SLOT_W'(0);
  localparam logic [SLOT_W-1:0] CODE1_SLOT  = SLOT_W'(1);
  localparam logic [SLOT_W-1:0] AUDIO_FIRST = SLOT_W'(4);
  localparam logic [SLOT_W-1:0] AUDIO_LAST  = SLOT_W'(4 + `AES_SAMPLE_W - 1);
  localparam logic [SLOT_W-1:0] V_SLOT      = SLOT_W'(4 + `AES_SAMPLE_W);
  localparam logic [SLOT_W-1:0] U_SLOT      = SLOT_W'(5 + `AES_SAMPLE_W);
  localparam logic [SLOT_W-1:0] C_SLOT      = SLOT_W'(6 + `AES_SAMPLE_W);

  // Slot currently on aud_data and the frame it belongs to
  logic [SLOT_W-1:0] slot_cnt;
  frame_idx_t        frame_cnt;

  // Values for the slot that goes out after this clock edge
  logic [SLOT_W-1:0] next_slot;
  logic              next_ws;
  logic              audio_slot;
  logic [`AES_LANES-1:0] slot_bit;

  // Captured audio, right word above left so one shift serves both subframes
  logic [2*`AES_SAMPLE_W-1:0] sh_q [`AES_LANES];
  logic [`AES_LANES-1:0]      valid_q;
  cs_fields_t                 cs_q;
  logic                       c_bit;

  assign next_slot  = slot_cnt + SLOT_W'(1);
  assign next_ws    = (slot_cnt == LAST_SLOT) ? ~aud_ws : aud_ws;
  assign audio_slot = (next_slot >= AUDIO_FIRST) && (next_slot <= AUDIO_LAST);
  assign c_bit      = cs_block_bit(cs_q, frame_cnt);

  // --------------------------------------------------
  // Slot and frame counters
  // --------------------------------------------------
  // The first frame after reset counts as the last of a block, so
  // the first captured pair lands in block frame 0
  always_ff @(posedge aud_clk) begin
    if (rst) begin
      slot_cnt   <= '0;
      frame_cnt  <= LAST_FRAME;
      aud_ws     <= 1'b0;
      sample_req <= 1'b0;
    end else begin
      slot_cnt <= next_slot;
      aud_ws   <= next_ws;
      // A new frame starts on the edge that captures the samples
      if (sample_req) begin
        frame_cnt <= (frame_cnt == LAST_FRAME) ? '0 : frame_cnt + frame_idx_t'(1);
      end
      // Raise the request during the last slot of the right subframe
      sample_req <= (next_slot == LAST_SLOT) && next_ws;
    end
  end

  // --------------------------------------------------
  // Sample capture and audio shift
  // --------------------------------------------------
  always_ff @(posedge aud_clk) begin
    for (int i = 0; i < `AES_LANES; i++) begin
      if (sample_req) begin
        sh_q[i]    <= {pcm_in[i].right, pcm_in[i].left};
        valid_q[i] <= pcm_in[i].valid;
      end else if (audio_slot) begin
        sh_q[i] <= sh_q[i] >> 1;
      end
    end
    // Hold the channel status steady for a whole block
    if (sample_req && (frame_cnt == LAST_FRAME)) begin
      cs_q <= cs_fields;
    end
  end

  // Bit of every lane for the next slot
  always_comb begin
    for (int i = 0; i < `AES_LANES; i++) begin
      if (audio_slot) begin
        slot_bit[i] = sh_q[i][0];
      end else begin
        case (next_slot)
          // Code 1x is a right subframe, 01 marks block start, 00 other lefts
          CODE0_SLOT: slot_bit[i] = next_ws;
          CODE1_SLOT: slot_bit[i] = ~next_ws && (frame_cnt == '0);
          V_SLOT:     slot_bit[i] = ~valid_q[i];
          U_SLOT:     slot_bit[i] = 1'b0;
          C_SLOT:     slot_bit[i] = c_bit;
          // Slots 2, 3 and the parity slot are filled in by the encoder
          default:    slot_bit[i] = 1'b0;
        endcase
      end
    end
  end

  always_ff @(posedge aud_clk) begin
    if (rst) begin
      aud_data <= '0;
    end else begin
      aud_data <= slot_bit;
    end
  end

endmodule

// File: verilog/aes_tx_top.sv
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_tx_top (
  input  logic                                      aud_clk,
  input  logic                                      rst,
  input  aes_frame_pkg::pcm_pair_t [`AES_LANES-1:0] pcm_in,
  input  aes_frame_pkg::cs_fields_t                 cs_fields,
  input  logic [`AES_LANES-1:0]                     lane_en,
  output logic                                      sample_req,
  output aes_line_pkg::line_sym_t [`AES_LANES-1:0]  line_out
);
  import aes_line_pkg::*;

  // Serial subframe stream, word select is common to all lanes
  logic                  aud_ws;
  logic [`AES_LANES-1:0] aud_data;

  // Encoded half-cell pairs before the output register
  line_sym_t [`AES_LANES-1:0] lane_sym;

  aes_subframe_feeder u_feeder (
    .aud_clk    (aud_clk),
    .rst        (rst),
    .pcm_in     (pcm_in),
    .cs_fields  (cs_fields),
    .sample_req (sample_req),
    .aud_ws     (aud_ws),
    .aud_data   (aud_data)
  );

  // --------------------------------------------------
  // One encoder per lane
  // --------------------------------------------------
  for (genvar g = 0; g < `AES_LANES; g++) begin : g_lane
    aes_lane_encoder u_encoder (
      .aud_clk  (aud_clk),
      .aud_ws   (aud_ws),
      .aud_data (aud_data[g]),
      .sym      (lane_sym[g])
    );
  end

  aes_line_output u_line_output (
    .aud_clk  (aud_clk),
    .rst      (rst),
    .lane_sym (lane_sym),
    .lane_en  (lane_en),
    .line_out (line_out)
  );

endmodule
